// ==== hdl/shadow_cfg.svh ====
`ifndef SHADOW_CFG_SVH
`define SHADOW_CFG_SVH

// vram word address width
// 14 gives 32 KB and 15 gives 64 KB
`define SHADOW_VRAM_AW 14

// other shadow rams, word address widths
`define SHADOW_CHAR_AW 11   // 4 KB
`define SHADOW_PAL_AW  11   // 4 KB
`define SHADOW_OBJ_AW  10   // 2 KB

// cpu byte addresses of each window
// window size comes from the matching width above
`define SHADOW_CPU_VRAM_BASE 24'h400000
`define SHADOW_CPU_CHAR_BASE 24'h410000
`define SHADOW_CPU_OBJ_BASE  24'h440000
`define SHADOW_CPU_PAL_BASE  24'h840000

`endif

// ==== hdl/shadow_pkg.sv ====
package shadow_pkg;

    typedef logic [15:0] word_t;        // cpu data word
    typedef logic [1:0]  wmask_t;       // bit 1 is the upper byte
    typedef logic [7:0]  byte_t;

    // cpu word address, bits 23..1 of the bus
    typedef logic [22:0] cpu_addr_t;

    // byte address on the dump side
    typedef logic [16:0] dump_addr_t;

    // word address inside one region
    // sized for the 64 KB vram
    typedef logic [14:0] local_addr_t;

    typedef enum logic [2:0] {
        REG_NONE,   // outside every window
        REG_VRAM,
        REG_CHAR,
        REG_PAL,
        REG_OBJ
    } region_e;

endpackage

// ==== hdl/shadow_wr_if.sv ====
// decoded cpu write bus
// one beat per write and no ready since the rams never stall
interface shadow_wr_if;
    import shadow_pkg::*;

    logic        valid;     // one cycle per write
    region_e     region;    // target ram
    local_addr_t addr;      // word offset in region
    word_t       data;
    wmask_t      mask;      // active high byte enables

    modport src (
        output valid,
        output region,
        output addr,
        output data,
        output mask
    );

    modport snk (
        input valid,
        input region,
        input addr,
        input data,
        input mask
    );

endinterface

// ==== hdl/shadow_ram16.sv ====
// 16-bit word ram
// byte masked write port and registered read port
module shadow_ram16 #(
    parameter int AW = 10
) (
    input  logic               clk_rom,
    input  shadow_pkg::wmask_t we,      // per byte
    input  logic [AW-1:0]      waddr,
    input  shadow_pkg::word_t  wdata,
    input  logic [AW-1:0]      raddr,
    output shadow_pkg::word_t  q
);
    import shadow_pkg::*;

    word_t mem [0:(1<<AW)-1];

    // write side
    always_ff @(posedge clk_rom) begin
        if (we[1]) begin
            mem[waddr][15:8] <= wdata[15:8];   // upper byte
        end
        if (we[0]) begin
            mem[waddr][7:0] <= wdata[7:0];     // lower byte
        end
    end

    // read side
    // same address collision returns the old word
    always_ff @(posedge clk_rom) begin
        q <= mem[raddr];
    end

    // a write with a bad address would corrupt an unknown word
    a_waddr_known : assert property (
        @(posedge clk_rom) (|we) |-> !$isunknown(waddr)
    );

endmodule

// ==== hdl/shadow_wr_decode.sv ====
`include "shadow_cfg.svh"

// cpu write decoder
// maps the cpu address onto one of the four shadow windows
module shadow_wr_decode (
    input  logic                  clk_rom,
    input  logic                  rst_n,
    input  logic                  cpu_wr,
    input  shadow_pkg::cpu_addr_t cpu_addr,
    input  shadow_pkg::word_t     cpu_data,
    input  shadow_pkg::wmask_t    cpu_dswn,    // active low
    shadow_wr_if.src              wr
);
    import shadow_pkg::*;

    // window bases as word addresses
    localparam cpu_addr_t VRAM_W = cpu_addr_t'(`SHADOW_CPU_VRAM_BASE >> 1);
    localparam cpu_addr_t CHAR_W = cpu_addr_t'(`SHADOW_CPU_CHAR_BASE >> 1);
    localparam cpu_addr_t PAL_W  = cpu_addr_t'(`SHADOW_CPU_PAL_BASE >> 1);
    localparam cpu_addr_t OBJ_W  = cpu_addr_t'(`SHADOW_CPU_OBJ_BASE >> 1);

    region_e     region_d;
    local_addr_t offs_d;
    wmask_t      mask_d;
    logic        keep;      // write lands in some ram

    // bases are aligned to their size so the upper bits decide
    function automatic logic hit(cpu_addr_t a, cpu_addr_t base, int aw);
        return (a >> aw) == (base >> aw);
    endfunction

    always_comb begin
        region_d = REG_NONE;
        offs_d   = '0;
        if (hit(cpu_addr, VRAM_W, `SHADOW_VRAM_AW)) begin
            region_d = REG_VRAM;
            offs_d   = local_addr_t'(cpu_addr[(`SHADOW_VRAM_AW)-1:0]);
        end else if (hit(cpu_addr, CHAR_W, `SHADOW_CHAR_AW)) begin
            region_d = REG_CHAR;
            offs_d   = local_addr_t'(cpu_addr[(`SHADOW_CHAR_AW)-1:0]);
        end else if (hit(cpu_addr, PAL_W, `SHADOW_PAL_AW)) begin
            region_d = REG_PAL;
            offs_d   = local_addr_t'(cpu_addr[(`SHADOW_PAL_AW)-1:0]);
        end else if (hit(cpu_addr, OBJ_W, `SHADOW_OBJ_AW)) begin
            region_d = REG_OBJ;
            offs_d   = local_addr_t'(cpu_addr[(`SHADOW_OBJ_AW)-1:0]);
        end
    end

    assign mask_d = ~cpu_dswn;     // strobes to enables
    assign keep   = cpu_wr && (region_d != REG_NONE) && (|mask_d);

    always_ff @(posedge clk_rom) begin
        if (!rst_n) begin
            wr.valid <= 1'b0;
        end else begin
            wr.valid <= keep;
        end
    end

    // payload only moves on a kept write
    always_ff @(posedge clk_rom) begin
        if (keep) begin
            wr.region <= region_d;
            wr.addr   <= offs_d;
            wr.data   <= cpu_data;
            wr.mask   <= mask_d;
        end
    end

    a_no_none : assert property (
        @(posedge clk_rom) disable iff (!rst_n) wr.valid |-> (wr.region != REG_NONE)
    );

endmodule

// ==== hdl/shadow_dump.sv ====
`include "shadow_cfg.svh"

// byte dump engine
// one request in flight, response two cycles after accept
module shadow_dump (
    input  logic                    clk_rom,
    input  logic                    rst_n,
    input  logic                    req_valid,
    output logic                    req_ready,
    input  shadow_pkg::dump_addr_t  req_addr,
    output logic                    rsp_valid,
    input  logic                    rsp_ready,
    output shadow_pkg::byte_t       rsp_data,
    output shadow_pkg::local_addr_t rd_addr,     // shared by all rams
    input  shadow_pkg::word_t       vram_q,
    input  shadow_pkg::word_t       char_q,
    input  shadow_pkg::word_t       pal_q,
    input  shadow_pkg::word_t       obj_q
);
    import shadow_pkg::*;

    localparam bit VRAM_BIG = (`SHADOW_VRAM_AW == 15);   // 64 KB vram

    typedef enum logic {
        IDLE,
        BUSY
    } state_e;

    state_e  state;
    logic    accept;
    logic    rd_pend;       // ram word arrives this cycle
    region_e region_d;
    region_e region_q;
    logic    lo_q;          // odd address picks low byte
    word_t   word_sel;
    byte_t   byte_sel;

    assign req_ready = (state == IDLE);
    assign accept    = req_valid && req_ready;
    assign rd_addr   = req_addr[15:1];      // word address

    // dump map
    always_comb begin
        if (VRAM_BIG && !req_addr[16]) begin
            region_d = REG_VRAM;
        end else begin
            casez (req_addr[16:11])
                6'b00????: region_d = REG_VRAM;     // 0000..7fff
                6'b01000?: region_d = REG_CHAR;     // 8000..8fff
                6'b01001?: region_d = REG_PAL;      // 9000..9fff
                6'b010100: region_d = REG_OBJ;      // a000..a7ff
                default:   region_d = REG_NONE;
            endcase
        end
    end

    always_comb begin
        case (region_q)
            REG_VRAM: word_sel = vram_q;
            REG_CHAR: word_sel = char_q;
            REG_PAL:  word_sel = pal_q;
            REG_OBJ:  word_sel = obj_q;
            default:  word_sel = 16'hffff;   // unmapped
        endcase
    end
    assign byte_sel = lo_q ? word_sel[7:0] : word_sel[15:8];   // even is upper

    always_ff @(posedge clk_rom) begin
        if (!rst_n) begin
            state     <= IDLE;
            rd_pend   <= 1'b0;
            rsp_valid <= 1'b0;
        end else begin
            rd_pend <= accept;
            case (state)
                IDLE: if (accept) state <= BUSY;
                BUSY: if (rsp_valid && rsp_ready) state <= IDLE;
                default: state <= IDLE;
            endcase
            if (rd_pend) begin
                rsp_valid <= 1'b1;
            end else if (rsp_ready) begin
                rsp_valid <= 1'b0;      // handed over
            end
        end
    end

    always_ff @(posedge clk_rom) begin
        if (accept) begin
            region_q <= region_d;
            lo_q     <= req_addr[0];
        end
        if (rd_pend) begin
            rsp_data <= byte_sel;       // held until taken
        end
    end

    a_rsp_hold : assert property (
        @(posedge clk_rom) disable iff (!rst_n)
        (rsp_valid && !rsp_ready) |=> (rsp_valid && $stable(rsp_data))
    );

endmodule

// ==== hdl/shadow_capture.sv ====
`include "shadow_cfg.svh"

// video memory shadow
// cpu writes go in on one side and a byte dump port reads them out
module shadow_capture (
    input  logic                   clk_rom,
    input  logic                   rst_n,
    // cpu bus
    input  logic                   cpu_wr,
    input  shadow_pkg::cpu_addr_t  cpu_addr,
    input  shadow_pkg::word_t      cpu_data,
    input  shadow_pkg::wmask_t     cpu_dswn,
    // dump request
    input  logic                   dump_req_valid,
    output logic                   dump_req_ready,
    input  shadow_pkg::dump_addr_t dump_addr,
    // dump response
    output logic                   dump_rsp_valid,
    input  logic                   dump_rsp_ready,
    output shadow_pkg::byte_t      dump_data
);
    import shadow_pkg::*;

    shadow_wr_if wr_bus ();

    local_addr_t rd_addr;
    word_t       vram_q, char_q, pal_q, obj_q;
    wmask_t      vram_we, char_we, pal_we, obj_we;

    shadow_wr_decode u_decode (
        .clk_rom  (clk_rom),
        .rst_n    (rst_n),
        .cpu_wr   (cpu_wr),
        .cpu_addr (cpu_addr),
        .cpu_data (cpu_data),
        .cpu_dswn (cpu_dswn),
        .wr       (wr_bus)
    );

    // region match gates the byte mask
    assign vram_we = (wr_bus.valid && wr_bus.region == REG_VRAM) ? wr_bus.mask : 2'b00;
    assign char_we = (wr_bus.valid && wr_bus.region == REG_CHAR) ? wr_bus.mask : 2'b00;
    assign pal_we  = (wr_bus.valid && wr_bus.region == REG_PAL)  ? wr_bus.mask : 2'b00;
    assign obj_we  = (wr_bus.valid && wr_bus.region == REG_OBJ)  ? wr_bus.mask : 2'b00;

    shadow_ram16 #(.AW(`SHADOW_VRAM_AW)) u_vram (
        .clk_rom (clk_rom),
        .we      (vram_we),
        .waddr   (wr_bus.addr[(`SHADOW_VRAM_AW)-1:0]),
        .wdata   (wr_bus.data),
        .raddr   (rd_addr[(`SHADOW_VRAM_AW)-1:0]),
        .q       (vram_q)
    );

    shadow_ram16 #(.AW(`SHADOW_CHAR_AW)) u_char (
        .clk_rom (clk_rom),
        .we      (char_we),
        .waddr   (wr_bus.addr[(`SHADOW_CHAR_AW)-1:0]),
        .wdata   (wr_bus.data),
        .raddr   (rd_addr[(`SHADOW_CHAR_AW)-1:0]),   // low bits of 8000..8fff
        .q       (char_q)
    );

    shadow_ram16 #(.AW(`SHADOW_PAL_AW)) u_pal (
        .clk_rom (clk_rom),
        .we      (pal_we),
        .waddr   (wr_bus.addr[(`SHADOW_PAL_AW)-1:0]),
        .wdata   (wr_bus.data),
        .raddr   (rd_addr[(`SHADOW_PAL_AW)-1:0]),
        .q       (pal_q)
    );

    shadow_ram16 #(.AW(`SHADOW_OBJ_AW)) u_obj (
        .clk_rom (clk_rom),
        .we      (obj_we),
        .waddr   (wr_bus.addr[(`SHADOW_OBJ_AW)-1:0]),
        .wdata   (wr_bus.data),
        .raddr   (rd_addr[(`SHADOW_OBJ_AW)-1:0]),
        .q       (obj_q)
    );

    shadow_dump u_dump (
        .clk_rom   (clk_rom),
        .rst_n     (rst_n),
        .req_valid (dump_req_valid),
        .req_ready (dump_req_ready),
        .req_addr  (dump_addr),
        .rsp_valid (dump_rsp_valid),
        .rsp_ready (dump_rsp_ready),
        .rsp_data  (dump_data),
        .rd_addr   (rd_addr),
        .vram_q    (vram_q),
        .char_q    (char_q),
        .pal_q     (pal_q),
        .obj_q     (obj_q)
    );

endmodule

// ==== sim/tb_shadow.sv ====
`include "shadow_cfg.svh"

module tb_shadow;
    timeunit 1ns;
    timeprecision 100ps;
    import shadow_pkg::*;

    localparam int CLK_NS     = 4;
    localparam int N_WR       = 32;                 // words per write phase
    localparam int N_OPS      = 10 * N_WR + 16;     // writes plus dumps with margin
    localparam int VRAM_BYTES = 2 << `SHADOW_VRAM_AW;

    logic       clk_rom = 1'b0;
    logic       rst_n;
    logic       cpu_wr;
    cpu_addr_t  cpu_addr;
    word_t      cpu_data;
    wmask_t     cpu_dswn;
    logic       dump_req_valid;
    logic       dump_req_ready;
    dump_addr_t dump_addr;
    logic       dump_rsp_valid;
    logic       dump_rsp_ready = 1'b1;
    byte_t      dump_data;

    integer      seed = 30;
    logic        bp_on = 1'b0;          // random response back-pressure
    byte_t       model_mem [4][65536];  // region, byte offset
    bit          model_wr  [4][65536];  // byte written at least once
    int unsigned pend_addr [$];         // accepted, no response yet
    int          pend_exp  [$];
    int unsigned word_list [$];         // dump address of each written word
    cpu_addr_t   cpu_list  [$];
    int          n_checked = 0;

    shadow_capture i_dut (.*);

    always #(CLK_NS / 2) clk_rom = ~clk_rom;

    // region order 0 vram, 1 char, 2 pal, 3 obj
    function automatic int unsigned cpu_base(int unsigned r);
        case (r)
            0: return 32'(`SHADOW_CPU_VRAM_BASE);
            1: return 32'(`SHADOW_CPU_CHAR_BASE);
            2: return 32'(`SHADOW_CPU_PAL_BASE);
            default: return 32'(`SHADOW_CPU_OBJ_BASE);
        endcase
    endfunction

    function automatic int unsigned region_bytes(int unsigned r);
        case (r)
            0: return 2 << `SHADOW_VRAM_AW;
            1: return 2 << `SHADOW_CHAR_AW;
            2: return 2 << `SHADOW_PAL_AW;
            default: return 2 << `SHADOW_OBJ_AW;
        endcase
    endfunction

    function automatic int unsigned dump_base(int unsigned r);
        return (r == 0) ? 0 : 'h8000 + (r - 1) * 'h1000;   // 4 KB steps after vram
    endfunction

    function automatic int unsigned rnd(int unsigned n);
        return {$random(seed)} % n;
    endfunction

    // applies a cpu write by window hit and active low strobes
    // upper byte sits at the even offset
    function automatic void model_write(cpu_addr_t a, word_t d, wmask_t dswn);
        int unsigned ba;
        logic [15:0] off;
        ba = {8'h00, a, 1'b0};
        for (int unsigned r = 0; r < 4; r++) begin
            if (ba >= cpu_base(r) && ba < cpu_base(r) + region_bytes(r)) begin
                off = 16'(ba - cpu_base(r));
                if (!dswn[1]) begin
                    model_mem[r[1:0]][off] = d[15:8];
                    model_wr[r[1:0]][off]  = 1'b1;
                end
                if (!dswn[0]) begin
                    model_mem[r[1:0]][off + 16'd1] = d[7:0];
                    model_wr[r[1:0]][off + 16'd1]  = 1'b1;
                end
            end
        end
    endfunction

    // expected dump byte or -1 when never written
    function automatic int ref_byte(int unsigned a);
        logic [1:0]  r;
        logic [15:0] off;
        if (a < VRAM_BYTES) begin
            r   = 2'd0;
            off = 16'(a);
        end else if (a >= 'h8000 && a < 'hA800) begin
            r   = 2'(((a - 'h8000) >> 12) + 1);    // char, pal, obj
            off = 16'(a & 'hFFF);
        end else begin
            return 'hFF;                         // unmapped
        end
        if (!model_wr[r][off]) return -1;
        return int'(model_mem[r][off]);
    endfunction

    task automatic report_and_stop(string msg);
        $display("%s", msg);
        $display("Test FAILED");
        $fatal(1, "stopped at first error");
    endtask

    task automatic cpu_write(cpu_addr_t a, word_t d, wmask_t dswn);
        cpu_wr   <= 1'b1;
        cpu_addr <= a;
        cpu_data <= d;
        cpu_dswn <= dswn;
        model_write(a, d, dswn);
        @(posedge clk_rom);
    endtask

    task automatic cpu_idle();
        cpu_wr <= 1'b0;
        repeat (3) @(posedge clk_rom);  // last write lands
    endtask

    task automatic dump_byte(int unsigned a);
        dump_req_valid <= 1'b1;
        dump_addr      <= dump_addr_t'(a);
        @(posedge clk_rom);
        while (!dump_req_ready) @(posedge clk_rom);   // until accepted
    endtask

    task automatic dump_word(int unsigned a);
        dump_byte(a);       // upper
        dump_byte(a + 1);   // lower
    endtask

    task automatic drain();
        dump_req_valid <= 1'b0;
        @(posedge clk_rom);
        while (pend_addr.size() != 0) @(posedge clk_rom);
    endtask

    always @(posedge clk_rom) dump_rsp_ready <= !bp_on || ($random(seed) % 2 == 0);

    // pairs each accepted request with its response
    always @(posedge clk_rom) begin : response_check
        int unsigned a;
        int          e;
        if (dump_req_valid && dump_req_ready) begin
            a = 32'(dump_addr);
            assert (pend_addr.size() == 0)
                else report_and_stop($sformatf("request %05h accepted with a response pending", a));
            pend_addr.push_back(a);
            pend_exp.push_back(ref_byte(a));
        end
        if (dump_rsp_valid && dump_rsp_ready) begin
            assert (pend_addr.size() != 0)
                else report_and_stop("a dump response came without a request");
            a = pend_addr.pop_front();
            e = pend_exp.pop_front();
            if (e >= 0) begin
                assert (dump_data == byte_t'(e))
                    else report_and_stop($sformatf("[FAIL] %0t: addr %05h got %02h expected %02h",
                                                   $time, a, dump_data, e));
                n_checked++;
            end
        end
    end

    initial begin : watchdog
        #(N_OPS * 20 * CLK_NS);
        report_and_stop("timeout, the run did not finish in time");
    end

    initial begin : stim
        int unsigned r;
        int unsigned off;
        int unsigned a;
        cpu_addr_t   ca;
        rst_n          = 1'b0;
        cpu_wr         = 1'b0;
        cpu_addr       = '0;
        cpu_data       = '0;
        cpu_dswn       = 2'b11;
        dump_req_valid = 1'b0;
        dump_addr      = '0;
        repeat (4) @(posedge clk_rom);
        rst_n <= 1'b1;
        @(posedge clk_rom);
        assert (!dump_rsp_valid && dump_req_ready)
            else report_and_stop($sformatf("[FAIL] %0t: after reset rsp_valid %b req_ready %b",
                                           $time, dump_rsp_valid, dump_req_ready));
        // full words in all four windows
        for (int i = 0; i < N_WR; i++) begin
            r   = rnd(4);
            off = rnd(region_bytes(r) / 2) * 2;
            ca  = cpu_addr_t'((cpu_base(r) + off) >> 1);
            cpu_write(ca, word_t'($random(seed)), 2'b00);
            word_list.push_back(dump_base(r) + off);
            cpu_list.push_back(ca);
        end
        cpu_idle();
        foreach (word_list[i]) dump_word(word_list[i]);
        drain();
        // single bytes over earlier words
        for (int i = 0; i < N_WR / 2; i++) begin
            cpu_write(cpu_list[i], word_t'($random(seed)), (rnd(2) != 0) ? 2'b01 : 2'b10);
        end
        cpu_idle();
        for (int i = 0; i < N_WR / 2; i++) dump_word(word_list[i]);
        drain();
        // no strobe and then gaps between the windows
        for (int i = 0; i < N_WR / 2; i++) begin
            cpu_write(cpu_list[i], word_t'($random(seed)), 2'b11);
            a = ((i % 2) != 0) ? 'h420000 + rnd('h10000) * 2 : 'h900000 + rnd('h10000) * 2;
            cpu_write(cpu_addr_t'(a >> 1), word_t'($random(seed)), 2'b00);
        end
        cpu_idle();
        for (int i = 0; i < N_WR / 2; i++) begin
            dump_word(word_list[i]);
            dump_byte('hA800 + rnd('h5800));
            dump_byte('h10000 + rnd('h10000));
        end
        drain();
        bp_on <= 1'b1;
        foreach (word_list[i]) dump_word(word_list[i]);
        drain();
        if (n_checked < 4 * N_WR) begin
            report_and_stop($sformatf("only %0d dump bytes were checked", n_checked));
        end else begin
            $display("%0d dump bytes checked", n_checked);
            $display("Test OK");
            $finish;
        end
    end

endmodule

// ==== compile.f ====
+incdir+hdl
hdl/shadow_pkg.sv
hdl/shadow_wr_if.sv
hdl/shadow_ram16.sv
hdl/shadow_wr_decode.sv
hdl/shadow_dump.sv
hdl/shadow_capture.sv
sim/tb_shadow.sv

// ==== Makefile ====
VERILATOR := verilator
VFLAGS    := --binary --timing -j 0
LINTFLAGS := --lint-only -Wall --timing
TOP       := tb_shadow
RTL_TOP   := shadow_capture
FILELIST  := compile.f
OBJDIR    := obj_dir
LOG       := sim.log

.PHONY: all build lint clean

all: build
	./$(OBJDIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "Test FAILED" $(LOG); then echo "simulation failed"; exit 1; fi
	@grep -q "Test OK" $(LOG) || (echo "no pass line in $(LOG)"; exit 1)

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJDIR)

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(RTL_TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJDIR) $(LOG)
